//--- hdl/stretchPkg.sv
// Stretcher shared definitions
`default_nettype none

package stretchPkg;

    // A chunk is the unit of transfer on both request sides
    localparam int chunkBits = 5;
    localparam int chunkSize = 1 << chunkBits;

    // Active frame size in columns and rows
    localparam int hActiveBits = 11;
    localparam int vActiveBits = 11;

    // Chunk numbers cover the whole active width
    localparam int chunkNumBits = hActiveBits - chunkBits;

    // A request carries the row in its upper bits and the chunk number below
    localparam int requestBits = vActiveBits + chunkNumBits;

    // RGB 5-6-5 pixels
    localparam int bitsPerPixel = 16;

    // Shrink factor has one integer bit, so 64 means 1.0
    localparam int scaleFractionBits = 6;
    localparam int scaleBits = scaleFractionBits + 1;

    // Source coordinate is a column with the factor's fraction appended
    localparam int hCoordBits = hActiveBits + scaleFractionBits;

    typedef logic [bitsPerPixel-1:0] pixelT;
    typedef logic [requestBits-1:0] requestT;
    typedef logic [chunkNumBits-1:0] chunkNumT;
    typedef logic [hCoordBits-1:0] hCoordT;
    typedef logic [scaleBits-1:0] scaleT;
    typedef logic [hActiveBits-1:0] columnT;

endpackage

`default_nettype wire

//--- hdl/syncFifo.sv
// Synchronous FIFO
`timescale 1ns/1ps
`default_nettype none

module syncFifo #(
    parameter type payloadT = logic [7:0],
    parameter int addrBits = 4
) (
    input  wire          scalerClock,
    input  wire          reset,
    input  wire          readEnable,
    input  wire          writeEnable,
    input  wire payloadT writeData,
    output logic         empty,
    output logic         full,
    output payloadT      readData
);

    localparam int depth = 1 << addrBits;

    payloadT storage [depth];

    // Pointers carry one extra wrap bit to tell full from empty
    logic [addrBits:0] readPointer;
    logic [addrBits:0] writePointer;
    logic doRead;
    logic doWrite;

    // Strobes on an empty or full FIFO are ignored
    assign doRead = readEnable && !empty;
    assign doWrite = writeEnable && !full;

    assign empty = (readPointer == writePointer);
    assign full = (readPointer[addrBits-1:0] == writePointer[addrBits-1:0]) &&
                  (readPointer[addrBits] != writePointer[addrBits]);

    always_ff @(posedge scalerClock or posedge reset) begin
        if (reset) begin
            readPointer <= '0;
            writePointer <= '0;
            // Readers compare this word before their first pop, so it starts defined
            readData <= '0;
        end else begin
            if (doWrite) begin
                writePointer <= writePointer + 1'b1;
            end
            // Read data shows up the cycle after the strobe
            if (doRead) begin
                readData <= storage[readPointer[addrBits-1:0]];
                readPointer <= readPointer + 1'b1;
            end
        end
    end

    always_ff @(posedge scalerClock) begin
        if (doWrite) begin
            storage[writePointer[addrBits-1:0]] <= writeData;
        end
    end

endmodule

`default_nettype wire

//--- hdl/requestTranslator.sv
// Downstream request translation
`timescale 1ns/1ps
`default_nettype none

module requestTranslator
    import stretchPkg::*;
(
    input  wire           scalerClock,
    input  wire           reset,
    input  wire scaleT    hShrinkFactor,
    input  wire           downstreamRequestEmpty,
    input  wire requestT  downstreamRequestData,
    input  wire           upstreamRequestFull,
    input  wire           pendingChunkFull,
    input  wire           pendingCoordFull,
    output logic          downstreamRequestReadEnable,
    output logic          upstreamRequestWriteEnable,
    output requestT       upstreamRequestWriteData,
    output logic          pendingCoordWriteEnable,
    output hCoordT        pendingCoordWriteData
);

    typedef enum logic [1:0] {idleState, readState, storeState} stateT;

    stateT state;
    logic [chunkBits-1:0] pixelCount;

    // The two most recent upstream requests, used to drop duplicates
    requestT lastRequest;
    requestT lastLastRequest;

    logic [vActiveBits-1:0] row;
    columnT column;
    hCoordT halfFactor;
    hCoordT halfPixel;
    hCoordT coordinate;
    chunkNumT coordChunk;
    requestT chunkRequest;
    requestT nextChunkRequest;
    logic needsNextChunk;
    logic issueCurrent;
    logic issueNext;
    logic stall;
    logic advance;

    // Output column is the requested chunk with the pixel counter below it
    assign row = downstreamRequestData[requestBits-1 -: vActiveBits];
    assign column = {downstreamRequestData[chunkNumBits-1:0], pixelCount};

    // Sample at the pixel centre, column * factor + factor / 2
    assign halfFactor = hCoordT'(hShrinkFactor >> 1);
    // Downscaling shifts back by half a source pixel to keep the image centred
    assign halfPixel = hShrinkFactor[scaleBits-1] ? hCoordT'(1 << (scaleFractionBits - 1)) : '0;
    assign coordinate = column * hShrinkFactor + halfFactor - halfPixel;

    assign coordChunk = coordinate[hCoordBits-1 -: chunkNumBits];
    assign chunkRequest = {row, coordChunk};
    assign nextChunkRequest = {row, coordChunk + 1'b1};

    // A sample between the last pixel of a chunk and the next one needs both chunks
    assign needsNextChunk = (&coordinate[hCoordBits-chunkNumBits-1 -: chunkBits]) &&
                            (|coordinate[scaleFractionBits-1:0]);

    assign issueCurrent = (chunkRequest != lastRequest) && (chunkRequest != lastLastRequest);
    assign issueNext = needsNextChunk && (nextChunkRequest != lastRequest) &&
                       (nextChunkRequest != lastLastRequest);

    // Any full FIFO holds the current coordinate for another cycle
    assign stall = upstreamRequestFull || pendingChunkFull || pendingCoordFull;
    assign advance = (state == storeState) && !stall;

    // Request data is valid in the store state, one cycle after this strobe
    assign downstreamRequestReadEnable = (state == readState);

    assign pendingCoordWriteEnable = advance;
    assign pendingCoordWriteData = coordinate;

    // At most one upstream request per coordinate, the current chunk first
    assign upstreamRequestWriteEnable = advance && (issueCurrent || issueNext);
    assign upstreamRequestWriteData = issueCurrent ? chunkRequest : nextChunkRequest;

    always_ff @(posedge scalerClock or posedge reset) begin
        if (reset) begin
            state <= idleState;
            pixelCount <= '0;
            lastRequest <= '1;
            lastLastRequest <= '1;
        end else begin
            case (state)
                idleState: begin
                    if (!downstreamRequestEmpty) begin
                        state <= readState;
                    end
                end

                readState: begin
                    pixelCount <= '0;
                    state <= storeState;
                end

                storeState: begin
                    if (advance) begin
                        pixelCount <= pixelCount + 1'b1;
                        // The whole chunk is done, go back for the next request
                        if (&pixelCount) begin
                            state <= idleState;
                        end
                    end
                end

                default: begin
                    state <= idleState;
                end
            endcase

            // Shift the duplicate filter whenever a request goes out
            if (upstreamRequestWriteEnable) begin
                lastRequest <= upstreamRequestWriteData;
                lastLastRequest <= lastRequest;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/chunkCache.sv
// Double chunk cache
`timescale 1ns/1ps
`default_nettype none

module chunkCache
    import stretchPkg::*;
(
    input  wire            scalerClock,
    input  wire            reset,
    input  wire            pendingChunkEmpty,
    input  wire chunkNumT  pendingChunkData,
    input  wire            upstreamResponseEmpty,
    input  wire pixelT     upstreamResponseData,
    input  wire columnT    leftColumn,
    input  wire columnT    rightColumn,
    input  wire            lookupActive,
    output logic           pendingChunkReadEnable,
    output logic           upstreamResponseReadEnable,
    output pixelT          leftColor,
    output pixelT          rightColor,
    output logic           bothCached
);

    typedef enum logic [1:0] {idleState, readState, storeState} stateT;

    stateT state;

    // Two caches, one is filled while the other serves lookups
    pixelT cacheMem [2][chunkSize];
    chunkNumT cacheTag [2];
    logic [1:0] cacheValid;
    // Index of the cache that gets refilled next
    logic olderCache;

    logic [chunkBits-1:0] pixelCount;
    logic storePending;
    logic storeCache;
    logic [chunkBits-1:0] storeIndex;

    chunkNumT leftChunk;
    chunkNumT rightChunk;
    logic [1:0] leftHit;
    logic [1:0] rightHit;
    logic leftSlot;
    logic rightSlot;
    logic olderNeeded;

    assign leftChunk = leftColumn[hActiveBits-1:chunkBits];
    assign rightChunk = rightColumn[hActiveBits-1:chunkBits];

    assign leftHit = {leftChunk == cacheTag[1], leftChunk == cacheTag[0]};
    assign rightHit = {rightChunk == cacheTag[1], rightChunk == cacheTag[0]};

    // Cache 0 wins when both tags match
    assign leftSlot = !leftHit[0];
    assign rightSlot = !rightHit[0];

    assign leftColor = cacheMem[leftSlot][leftColumn[chunkBits-1:0]];
    assign rightColor = cacheMem[rightSlot][rightColumn[chunkBits-1:0]];

    assign bothCached = lookupActive &&
                        leftHit[leftSlot] && cacheValid[leftSlot] &&
                        rightHit[rightSlot] && cacheValid[rightSlot];

    // The older cache stays untouched while either column still points into it
    assign olderNeeded = leftHit[olderCache] || rightHit[olderCache];

    assign pendingChunkReadEnable = (state == idleState) && !pendingChunkEmpty;
    assign upstreamResponseReadEnable = (state == storeState) && !upstreamResponseEmpty;

    always_ff @(posedge scalerClock or posedge reset) begin
        if (reset) begin
            state <= idleState;
            cacheTag[0] <= '1;
            cacheTag[1] <= '1;
            cacheValid <= '0;
            olderCache <= 1'b0;
            pixelCount <= '0;
            storePending <= 1'b0;
            storeCache <= 1'b0;
            storeIndex <= '0;
        end else begin
            case (state)
                idleState: begin
                    if (pendingChunkReadEnable) begin
                        state <= readState;
                    end
                end

                readState: begin
                    // Chunk number is valid now, claim the older cache once it is free
                    if (!olderNeeded) begin
                        cacheTag[olderCache] <= pendingChunkData;
                        cacheValid[olderCache] <= 1'b0;
                        pixelCount <= '0;
                        state <= storeState;
                    end
                end

                storeState: begin
                    if (upstreamResponseReadEnable) begin
                        pixelCount <= pixelCount + 1'b1;
                        if (&pixelCount) begin
                            // Filled cache becomes the newer one
                            olderCache <= !olderCache;
                            state <= idleState;
                        end
                    end
                end

                default: begin
                    state <= idleState;
                end
            endcase

            // Remember where each popped pixel goes, it arrives next cycle
            storePending <= upstreamResponseReadEnable;
            storeCache <= olderCache;
            storeIndex <= pixelCount;

            if (storePending && (&storeIndex)) begin
                cacheValid[storeCache] <= 1'b1;
            end
        end
    end

    always_ff @(posedge scalerClock) begin
        if (storePending) begin
            cacheMem[storeCache][storeIndex] <= upstreamResponseData;
        end
    end

endmodule

`default_nettype wire

//--- hdl/pixelBlender.sv
// Linear pixel blender
`timescale 1ns/1ps
`default_nettype none

module pixelBlender
    import stretchPkg::*;
(
    input  wire          scalerClock,
    input  wire          reset,
    input  wire          pendingCoordEmpty,
    input  wire hCoordT  pendingCoordData,
    input  wire pixelT   leftColor,
    input  wire pixelT   rightColor,
    input  wire          bothCached,
    input  wire          downstreamResponseFull,
    output logic         pendingCoordReadEnable,
    output columnT       leftColumn,
    output columnT       rightColumn,
    output logic         lookupActive,
    output logic         downstreamResponseWriteEnable,
    output pixelT        downstreamResponseWriteData
);

    // Set while a popped coordinate waits for its pixels
    logic available;
    logic [scaleFractionBits-1:0] fraction;
    logic [5:0] red;
    logic [5:0] green;
    logic [5:0] blue;

    // Weighted sum of two channel values where the left weight is 63 minus the fraction
    function automatic logic [5:0] blendChannel(
        input logic [5:0] leftValue,
        input logic [5:0] rightValue,
        input logic [scaleFractionBits-1:0] weight
    );
        logic [scaleFractionBits-1:0] leftWeight;
        logic [2*scaleFractionBits-1:0] sum;
        // Six-bit complement gives 63 minus the fraction
        leftWeight = ~weight;
        sum = leftValue * leftWeight + rightValue * weight;
        return sum[2*scaleFractionBits-1:scaleFractionBits];
    endfunction

    assign leftColumn = pendingCoordData[hCoordBits-1:scaleFractionBits];
    assign fraction = pendingCoordData[scaleFractionBits-1:0];
    // With no fraction the right pixel adds nothing, so stay inside the left chunk
    assign rightColumn = (fraction == '0) ? leftColumn : leftColumn + 1'b1;

    assign lookupActive = available;

    assign red = blendChannel({1'b0, leftColor[15:11]}, {1'b0, rightColor[15:11]}, fraction);
    assign green = blendChannel(leftColor[10:5], rightColor[10:5], fraction);
    assign blue = blendChannel({1'b0, leftColor[4:0]}, {1'b0, rightColor[4:0]}, fraction);

    assign downstreamResponseWriteData = {red[4:0], green, blue[4:0]};

    assign downstreamResponseWriteEnable = available && bothCached && !downstreamResponseFull;

    // Pop the next coordinate when nothing is held or the held one is written now
    assign pendingCoordReadEnable = !downstreamResponseFull && !pendingCoordEmpty &&
                                    (!available || downstreamResponseWriteEnable);

    always_ff @(posedge scalerClock or posedge reset) begin
        if (reset) begin
            available <= 1'b0;
        end else if (pendingCoordReadEnable) begin
            available <= 1'b1;
        end else if (downstreamResponseWriteEnable) begin
            available <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- hdl/videoHorizontalStretch.sv
// Horizontal video stretcher
`timescale 1ns/1ps
`default_nettype none

module videoHorizontalStretch
    import stretchPkg::*;
(
    input  wire          scalerClock,
    input  wire          reset,
    input  wire scaleT   hShrinkFactor,
    // External downstream request FIFO, read side
    input  wire          downstreamRequestEmpty,
    input  wire requestT downstreamRequestData,
    output logic         downstreamRequestReadEnable,
    // External downstream response FIFO, write side
    input  wire          downstreamResponseFull,
    output logic         downstreamResponseWriteEnable,
    output pixelT        downstreamResponseWriteData,
    // Upstream request FIFO, read from outside
    input  wire          upstreamRequestReadEnable,
    output logic         upstreamRequestEmpty,
    output requestT      upstreamRequestData,
    // Upstream response FIFO, written from outside
    input  wire          upstreamResponseWriteEnable,
    input  wire pixelT   upstreamResponseWriteData,
    output logic         upstreamResponseFull
);

    logic upstreamRequestWriteEnable;
    logic upstreamRequestFull;
    requestT upstreamRequestWriteData;
    logic pendingChunkReadEnable;
    logic pendingChunkEmpty;
    logic pendingChunkFull;
    chunkNumT pendingChunkData;
    logic pendingCoordWriteEnable;
    logic pendingCoordReadEnable;
    logic pendingCoordEmpty;
    logic pendingCoordFull;
    hCoordT pendingCoordWriteData;
    hCoordT pendingCoordData;
    logic upstreamResponseReadEnable;
    logic upstreamResponseEmpty;
    pixelT upstreamResponseData;
    columnT leftColumn;
    columnT rightColumn;
    logic lookupActive;
    pixelT leftColor;
    pixelT rightColor;
    logic bothCached;

    requestTranslator translator (
        .scalerClock, .reset, .hShrinkFactor,
        .downstreamRequestEmpty, .downstreamRequestData,
        .upstreamRequestFull, .pendingChunkFull, .pendingCoordFull,
        .downstreamRequestReadEnable,
        .upstreamRequestWriteEnable, .upstreamRequestWriteData,
        .pendingCoordWriteEnable, .pendingCoordWriteData
    );

    // Chunk requests handed to the upstream element
    syncFifo #(.payloadT(requestT), .addrBits(6)) upstreamRequests (
        .scalerClock, .reset,
        .readEnable(upstreamRequestReadEnable), .writeEnable(upstreamRequestWriteEnable),
        .writeData(upstreamRequestWriteData), .empty(upstreamRequestEmpty),
        .full(upstreamRequestFull), .readData(upstreamRequestData)
    );

    // Same requests, chunk number only, telling the cache what each pixel burst is
    syncFifo #(.payloadT(chunkNumT), .addrBits(6)) pendingChunks (
        .scalerClock, .reset,
        .readEnable(pendingChunkReadEnable), .writeEnable(upstreamRequestWriteEnable),
        .writeData(upstreamRequestWriteData[chunkNumBits-1:0]), .empty(pendingChunkEmpty),
        .full(pendingChunkFull), .readData(pendingChunkData)
    );

    // Source coordinates of output pixels not yet blended
    syncFifo #(.payloadT(hCoordT), .addrBits(6)) pendingCoords (
        .scalerClock, .reset,
        .readEnable(pendingCoordReadEnable), .writeEnable(pendingCoordWriteEnable),
        .writeData(pendingCoordWriteData), .empty(pendingCoordEmpty),
        .full(pendingCoordFull), .readData(pendingCoordData)
    );

    // Pixels arriving from the upstream element, one chunk deep
    syncFifo #(.payloadT(pixelT), .addrBits(chunkBits)) upstreamResponses (
        .scalerClock, .reset,
        .readEnable(upstreamResponseReadEnable), .writeEnable(upstreamResponseWriteEnable),
        .writeData(upstreamResponseWriteData), .empty(upstreamResponseEmpty),
        .full(upstreamResponseFull), .readData(upstreamResponseData)
    );

    chunkCache cache (
        .scalerClock, .reset,
        .pendingChunkEmpty, .pendingChunkData,
        .upstreamResponseEmpty, .upstreamResponseData,
        .leftColumn, .rightColumn, .lookupActive,
        .pendingChunkReadEnable, .upstreamResponseReadEnable,
        .leftColor, .rightColor, .bothCached
    );

    pixelBlender blender (
        .scalerClock, .reset,
        .pendingCoordEmpty, .pendingCoordData,
        .leftColor, .rightColor, .bothCached, .downstreamResponseFull,
        .pendingCoordReadEnable, .leftColumn, .rightColumn, .lookupActive,
        .downstreamResponseWriteEnable, .downstreamResponseWriteData
    );

endmodule

`default_nettype wire

//--- bench/stretchBind_assert.sv
// Stretcher strobe assertions
`timescale 1ns/1ps
`default_nettype none

module stretchChecks (
    input wire scalerClock,
    input wire reset,
    input wire downstreamRequestEmpty,
    input wire downstreamRequestReadEnable,
    input wire downstreamResponseFull,
    input wire downstreamResponseWriteEnable,
    input wire upstreamRequestEmpty
);

    // Number of assertion failures seen so far
    int failureCount = 0;

    // A write into a full response FIFO would drop a pixel
    responseWriteWhileFull: assert property (@(posedge scalerClock) disable iff (reset)
        downstreamResponseWriteEnable |-> !downstreamResponseFull)
        else begin
            $error("Downstream response written while the FIFO is full");
            failureCount++;
        end

    // The external request FIFO must never be popped empty
    requestReadWhileEmpty: assert property (@(posedge scalerClock) disable iff (reset)
        downstreamRequestReadEnable |-> !downstreamRequestEmpty)
        else begin
            $error("Downstream request read while the FIFO is empty");
            failureCount++;
        end

    // Sampled on the falling edge so the asynchronous reset has settled
    quietDuringReset: assert property (@(negedge scalerClock)
        reset |-> (!downstreamRequestReadEnable && !downstreamResponseWriteEnable &&
                   upstreamRequestEmpty))
        else begin
            $error("Output strobe active during reset");
            failureCount++;
        end

endmodule

bind videoHorizontalStretch stretchChecks checks (.*);

`default_nettype wire

//--- bench/stretchBench.sv
// Horizontal stretcher testbench
`timescale 1ns/1ps
`default_nettype none

module stretchBench
    import stretchPkg::*;
();

    localparam int clockPeriod = 100;
    localparam int chunkTimeout = 3000;

    logic scalerClock;
    logic reset;
    scaleT hShrinkFactor;
    logic downstreamRequestEmpty;
    requestT downstreamRequestData;
    logic downstreamRequestReadEnable;
    logic downstreamResponseFull;
    logic downstreamResponseWriteEnable;
    pixelT downstreamResponseWriteData;
    logic upstreamRequestReadEnable;
    logic upstreamRequestEmpty;
    requestT upstreamRequestData;
    logic upstreamResponseWriteEnable;
    pixelT upstreamResponseWriteData;
    logic upstreamResponseFull;

    integer seed = 50782;
    requestT requestQueue[$];
    pixelT expectedQueue[$];
    // Row of every downstream request in the running phase
    logic [vActiveBits-1:0] phaseRow;
    bit stressMode;
    bit timedOut;
    int mismatchCount;
    int protocolCount;
    int timeoutCount;
    int checkedCount;
    int totalRequested;

    // Upstream model state
    int fetchStage;
    int pixelIndex;
    requestT currentRequest;
    requestT previousRequest;
    requestT olderRequest;
    int requestsSeen;

    videoHorizontalStretch UUT (.*);

    always #(clockPeriod / 2) scalerClock = !scalerClock;

    // Source image content, every pixel depends on both row and column
    function automatic pixelT sourcePixel(input int row, input int column);
        logic [31:0] mix;
        mix = column * 40503 + row * 7919 + 12345;
        return mix[15:0] ^ mix[26:11];
    endfunction

    // Expected output pixel for one output column
    function automatic pixelT expectedPixel(input int row, input int column, input int factor);
        int coord;
        int frac;
        int left;
        int right;
        pixelT a;
        pixelT b;
        int red;
        int green;
        int blue;
        // Pixel centre of the output column, mapped into source space
        coord = column * factor + factor / 2;
        if (factor >= 64) begin
            coord = coord - 32;
        end
        coord = coord & 'h1ffff;
        left = coord >> 6;
        frac = coord & 63;
        right = (frac == 0) ? left : left + 1;
        a = sourcePixel(row, left);
        b = sourcePixel(row, right);
        red = (a[15:11] * (63 - frac) + b[15:11] * frac) >> 6;
        green = (a[10:5] * (63 - frac) + b[10:5] * frac) >> 6;
        blue = (a[4:0] * (63 - frac) + b[4:0] * frac) >> 6;
        return {red[4:0], green[5:0], blue[4:0]};
    endfunction

    // Each upstream request carries the row of the running phase and differs from the last two
    task automatic checkUpstreamRequest(input requestT request);
        logic [vActiveBits-1:0] requestRow;
        requestRow = request[requestBits-1 -: vActiveBits];
        if (requestRow != phaseRow) begin
            $display("Fail at %0t: upstream request %h names row %0d, expected row %0d",
                     $time, request, requestRow, phaseRow);
            mismatchCount++;
        end
        if ((requestsSeen >= 1 && request == previousRequest) ||
            (requestsSeen >= 2 && request == olderRequest)) begin
            $display("Fail at %0t: upstream request %h repeats within three requests",
                     $time, request);
            mismatchCount++;
        end
        olderRequest = previousRequest;
        previousRequest = request;
        requestsSeen++;
    endtask

    // External downstream request FIFO, read data registered on the strobe
    always @(posedge scalerClock) begin : requestSource
        requestT front;
        if (reset) begin
            downstreamRequestEmpty <= 1'b1;
        end else if (downstreamRequestReadEnable && !downstreamRequestEmpty) begin
            front = requestQueue.pop_front();
            downstreamRequestData <= front;
            downstreamRequestEmpty <= (requestQueue.size() == 0);
        end else begin
            downstreamRequestEmpty <= (requestQueue.size() == 0);
        end
    end

    // Upstream element and downstream back-pressure share one random stream
    always @(posedge scalerClock) begin : upstreamSource
        logic gap;
        gap = ($unsigned($random(seed)) % 3) == 0;
        downstreamResponseFull <= stressMode && (($unsigned($random(seed)) % 3) == 0);
        upstreamRequestReadEnable <= 1'b0;
        upstreamResponseWriteEnable <= 1'b0;
        if (reset) begin
            fetchStage <= 0;
        end else begin
            case (fetchStage)
                0: begin
                    if (!upstreamRequestEmpty) begin
                        upstreamRequestReadEnable <= 1'b1;
                        fetchStage <= 1;
                    end
                end
                // FIFO sees the strobe here, data follows one cycle later
                1: fetchStage <= 2;
                2: begin
                    checkUpstreamRequest(upstreamRequestData);
                    currentRequest <= upstreamRequestData;
                    pixelIndex <= 0;
                    fetchStage <= 3;
                end
                default: begin
                    // Full lags one write, so never write two cycles in a row
                    if (!gap && !upstreamResponseFull && !upstreamResponseWriteEnable) begin
                        upstreamResponseWriteEnable <= 1'b1;
                        upstreamResponseWriteData <= sourcePixel(
                            currentRequest[requestBits-1 -: vActiveBits],
                            currentRequest[chunkNumBits-1:0] * chunkSize + pixelIndex);
                        pixelIndex <= pixelIndex + 1;
                        if (pixelIndex == chunkSize - 1) begin
                            fetchStage <= 0;
                        end
                    end
                end
            endcase
        end
    end

    // Compare every response write against the reference, in order
    always @(posedge scalerClock) begin : responseCheck
        pixelT expected;
        if (!reset && downstreamResponseWriteEnable) begin
            if (expectedQueue.size() == 0) begin
                $display("Response pixel %h written at %0t with no request outstanding",
                         downstreamResponseWriteData, $time);
                protocolCount++;
            end else begin
                expected = expectedQueue.pop_front();
                if (downstreamResponseWriteData !== expected) begin
                    $display("Fail at %0t: response pixel %0d is %h, expected %h",
                             $time, checkedCount, downstreamResponseWriteData, expected);
                    mismatchCount++;
                end
                checkedCount++;
            end
        end
    end

    // Strobes stay low and the upstream request FIFO stays empty
    task automatic checkQuiet(input int cycle);
        if (downstreamRequestReadEnable !== 1'b0 || downstreamResponseWriteEnable !== 1'b0 ||
            upstreamRequestEmpty !== 1'b1) begin
            $display("Fail at %0t: outputs active in cycle %0d around reset", $time, cycle);
            mismatchCount++;
        end
    endtask

    task automatic sendRequest(input int row, input int chunk, input int factor);
        int column;
        @(negedge scalerClock);
        requestQueue.push_back({row[vActiveBits-1:0], chunk[chunkNumBits-1:0]});
        for (column = chunk * chunkSize; column < (chunk + 1) * chunkSize; column++) begin
            expectedQueue.push_back(expectedPixel(row, column, factor));
        end
        totalRequested += chunkSize;
    endtask

    // Consecutive chunks of one row at one factor, then wait for all pixels
    task automatic runPhase(input int row, input int firstChunk, input int chunkCount,
                            input int factor, input bit stress);
        int chunk;
        int waitCycles;
        @(posedge scalerClock);
        hShrinkFactor <= scaleT'(factor);
        stressMode <= stress;
        phaseRow <= row[vActiveBits-1:0];
        for (chunk = firstChunk; chunk < firstChunk + chunkCount; chunk++) begin
            sendRequest(row, chunk, factor);
        end
        waitCycles = 0;
        while (expectedQueue.size() != 0 && waitCycles < chunkCount * chunkTimeout) begin
            @(posedge scalerClock);
            waitCycles++;
        end
        if (expectedQueue.size() != 0) begin
            $display("Timed out with %0d pixels of row %0d at factor %0d never written",
                     expectedQueue.size(), row, factor);
            timeoutCount++;
            timedOut = 1'b1;
        end
        stressMode <= 1'b0;
    endtask

    initial begin : mainSequence
        int cycle;
        scalerClock = 1'b0;
        reset = 1'b1;
        hShrinkFactor = 7'd64;
        downstreamRequestEmpty = 1'b1;
        downstreamRequestData = '0;
        downstreamResponseFull = 1'b0;
        upstreamRequestReadEnable = 1'b0;
        upstreamResponseWriteEnable = 1'b0;
        upstreamResponseWriteData = '0;
        phaseRow = '0;
        // Reset drops on the fourth rising edge, checks skip the first unsettled edge
        for (cycle = 0; cycle < 8; cycle++) begin
            @(posedge scalerClock);
            if (cycle == 3) begin
                reset <= 1'b0;
            end
            if (cycle > 0) begin
                checkQuiet(cycle);
            end
        end
        // Unit factor on two neighbouring chunks
        runPhase(3, 4, 2, 64, 1'b0);
        // Upscaling across chunk edges
        if (!timedOut) begin
            runPhase(9, 0, 4, 40, 1'b0);
        end
        // Downscaling, upstream requests are checked as they are popped
        if (!timedOut) begin
            runPhase(17, 0, 4, 100, 1'b0);
        end
        // Random back-pressure on top of the random upstream gaps
        if (!timedOut) begin
            runPhase(25, 0, 6, 90, 1'b1);
        end
        // Leave room for stray writes to show up
        repeat (20) @(posedge scalerClock);
        $display("Errors: %0d mismatch, %0d protocol, %0d assertion, %0d timeout, %0d/%0d checked",
                 mismatchCount, protocolCount, UUT.checks.failureCount, timeoutCount,
                 checkedCount, totalRequested);
        if (mismatchCount == 0 && protocolCount == 0 && timeoutCount == 0 &&
            UUT.checks.failureCount == 0 && checkedCount == totalRequested) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
hdl/stretchPkg.sv
hdl/syncFifo.sv
hdl/requestTranslator.sv
hdl/chunkCache.sv
hdl/pixelBlender.sv
hdl/videoHorizontalStretch.sv
bench/stretchBind_assert.sv
bench/stretchBench.sv
